//--- source/sprite_pkg.sv
package sprite_pkg;

    // Display geometry
    localparam int SCREEN_WIDTH = 640;
    localparam int SCREEN_HEIGHT = 400;
    localparam int SCREEN_PIXELS = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int ADDRESS_BITS = 18;
    localparam int COORD_BITS = 10;

    // Host command opcodes, one byte each
    typedef enum logic [7:0] {
        OP_SET_POSITION = 8'h01,
        OP_SET_WIDTH    = 8'h02,
        OP_SET_MODE     = 8'h03,
        OP_DRAW         = 8'h04
    } opcode_t;

    // Code 2'b11 is reserved and decodes like MODE_4BPP
    typedef enum logic [1:0] {
        MODE_1BPP = 2'd0,
        MODE_2BPP = 2'd1,
        MODE_4BPP = 2'd2
    } bpp_mode_t;

    typedef enum logic [2:0] {
        IDLE,
        ARGS,
        COUNT,
        DATA
    } decode_state_t;

    typedef struct packed {
        logic [COORD_BITS-1:0] x_origin;
        logic [COORD_BITS-1:0] y_origin;
        logic [COORD_BITS-1:0] width;
        bpp_mode_t             mode;
        logic [3:0]            palette_offset;
    } sprite_setup_t;

    typedef struct packed {
        logic       valid;
        logic       first;
        logic [7:0] data;
    } sprite_byte_t;

    typedef struct packed {
        logic                  valid;
        logic [COORD_BITS-1:0] x;
        logic [COORD_BITS-1:0] y;
        logic [3:0]            index;
    } pixel_item_t;

    typedef struct packed {
        logic                    enable;
        logic [ADDRESS_BITS-1:0] address;
        logic [3:0]              color;
    } pixel_write_t;

    // Setup after reset: origin 0,0, one pixel wide, 4 bpp, no offset
    localparam sprite_setup_t SETUP_RESET = '{
        x_origin:       '0,
        y_origin:       '0,
        width:          10'd1,
        mode:           MODE_4BPP,
        palette_offset: 4'd0
    };

endpackage

//--- source/command_decoder.sv
`timescale 1ns/1ps

module command_decoder import sprite_pkg::*; (
    input  logic          clock_in,
    input  logic          arst_n,
    input  logic          cmd_valid,
    input  logic [7:0]    cmd_byte,
    output sprite_setup_t setup,
    output sprite_byte_t  byte_out
);

    decode_state_t state;
    opcode_t       current_op;
    logic [1:0]    args_left;
    logic [23:0]   arg_buffer;
    logic [15:0]   bytes_left;
    logic [15:0]   draw_count;
    logic          first_pending;

    // Byte count of a DRAW, high byte already buffered
    assign draw_count = {arg_buffer[7:0], cmd_byte};

    // Earlier argument bytes, oldest in the upper bits
    always_ff @(posedge clock_in) begin
        if (cmd_valid && (state == ARGS || state == COUNT)) begin
            arg_buffer <= {arg_buffer[15:0], cmd_byte};
        end
    end

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            current_op <= OP_SET_POSITION;
            args_left <= '0;
            bytes_left <= '0;
            first_pending <= 1'b0;
            setup <= SETUP_RESET;
            byte_out <= '0;
        end else begin
            byte_out.valid <= 1'b0;

            if (cmd_valid) begin
                case (state)
                    IDLE: begin
                        case (opcode_t'(cmd_byte))
                            OP_SET_POSITION: begin
                                current_op <= OP_SET_POSITION;
                                args_left <= 2'd3;
                                state <= ARGS;
                            end
                            OP_SET_WIDTH: begin
                                current_op <= OP_SET_WIDTH;
                                args_left <= 2'd1;
                                state <= ARGS;
                            end
                            OP_SET_MODE: begin
                                current_op <= OP_SET_MODE;
                                args_left <= 2'd0;
                                state <= ARGS;
                            end
                            OP_DRAW: begin
                                current_op <= OP_DRAW;
                                args_left <= 2'd1;
                                state <= COUNT;
                            end
                            // Anything else is dropped silently
                            default: begin
                                state <= IDLE;
                            end
                        endcase
                    end

                    ARGS: begin
                        if (args_left != 2'd0) begin
                            args_left <= args_left - 2'd1;
                        end else begin
                            state <= IDLE;
                            case (current_op)
                                OP_SET_POSITION: begin
                                    setup.x_origin <= {arg_buffer[17:16], arg_buffer[15:8]};
                                    setup.y_origin <= {arg_buffer[1:0], cmd_byte};
                                end
                                OP_SET_WIDTH: begin
                                    setup.width <= {arg_buffer[1:0], cmd_byte};
                                end
                                OP_SET_MODE: begin
                                    setup.mode <= bpp_mode_t'(cmd_byte[1:0]);
                                    setup.palette_offset <= cmd_byte[7:4];
                                end
                                default: begin
                                    state <= IDLE;
                                end
                            endcase
                        end
                    end

                    COUNT: begin
                        if (args_left != 2'd0) begin
                            args_left <= args_left - 2'd1;
                        end else if (draw_count == 16'd0) begin
                            // Empty draw, nothing to stream
                            state <= IDLE;
                        end else begin
                            bytes_left <= draw_count;
                            first_pending <= 1'b1;
                            state <= DATA;
                        end
                    end

                    DATA: begin
                        byte_out <= '{valid: 1'b1, first: first_pending, data: cmd_byte};
                        first_pending <= 1'b0;
                        bytes_left <= bytes_left - 16'd1;
                        if (bytes_left == 16'd1) begin
                            state <= IDLE;
                        end
                    end

                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    state_legal_a: assert property (
        @(posedge clock_in) disable iff (!arst_n)
        state inside {IDLE, ARGS, COUNT, DATA}
    );

endmodule

//--- source/pixel_unpacker.sv
`timescale 1ns/1ps

module pixel_unpacker import sprite_pkg::*; (
    input  logic          clock_in,
    input  logic          arst_n,
    input  sprite_setup_t setup,
    input  sprite_byte_t  byte_in,
    output pixel_item_t   item
);

    logic [7:0]            shift_reg;
    logic [3:0]            pixels_left;
    logic [3:0]            pixels_per_byte;
    logic [COORD_BITS-1:0] pen_x;
    logic [COORD_BITS-1:0] pen_y;
    logic [COORD_BITS-1:0] row_count;

    logic [7:0]            src_byte;
    logic [7:0]            next_shift;
    logic [3:0]            pixel_index;
    logic                  emit;
    logic                  restart;
    logic                  row_end;
    logic [COORD_BITS-1:0] cur_x;
    logic [COORD_BITS-1:0] cur_y;
    logic [COORD_BITS-1:0] cur_count;

    // First pixel comes straight from the incoming byte
    assign src_byte = byte_in.valid ? byte_in.data : shift_reg;
    assign emit = byte_in.valid || (pixels_left != 4'd0);

    // A new DRAW puts the pen back at the origin
    assign restart = byte_in.valid && byte_in.first;
    assign cur_x = restart ? setup.x_origin : pen_x;
    assign cur_y = restart ? setup.y_origin : pen_y;
    assign cur_count = restart ? '0 : row_count;
    assign row_end = (cur_count + 10'd1) >= setup.width;

    // MSB first, index zero-extended to 4 bits
    always_comb begin
        case (setup.mode)
            MODE_1BPP: begin
                pixels_per_byte = 4'd8;
                pixel_index = {3'b000, src_byte[7]};
                next_shift = {src_byte[6:0], 1'b0};
            end
            MODE_2BPP: begin
                pixels_per_byte = 4'd4;
                pixel_index = {2'b00, src_byte[7:6]};
                next_shift = {src_byte[5:0], 2'b00};
            end
            default: begin
                pixels_per_byte = 4'd2;
                pixel_index = src_byte[7:4];
                next_shift = {src_byte[3:0], 4'b0000};
            end
        endcase
    end

    always_ff @(posedge clock_in) begin
        if (emit) begin
            shift_reg <= next_shift;
        end
    end

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            pixels_left <= '0;
            pen_x <= '0;
            pen_y <= '0;
            row_count <= '0;
            item <= '0;
        end else begin
            item.valid <= emit;

            if (byte_in.valid) begin
                pixels_left <= pixels_per_byte - 4'd1;
            end else if (pixels_left != 4'd0) begin
                pixels_left <= pixels_left - 4'd1;
            end

            if (emit) begin
                item.x <= cur_x;
                item.y <= cur_y;
                item.index <= pixel_index;

                // Wrap to next row once width pixels are out
                if (row_end) begin
                    pen_x <= setup.x_origin;
                    pen_y <= cur_y + 10'd1;
                    row_count <= '0;
                end else begin
                    pen_x <= cur_x + 10'd1;
                    pen_y <= cur_y;
                    row_count <= cur_count + 10'd1;
                end
            end
        end
    end

    // Host must leave room for the previous byte to drain
    no_overrun_a: assert property (
        @(posedge clock_in) disable iff (!arst_n)
        byte_in.valid |-> (pixels_left == 4'd0)
    );

    width_nonzero_a: assert property (
        @(posedge clock_in) disable iff (!arst_n)
        byte_in.valid |-> (setup.width != '0)
    );

endmodule

//--- source/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer import sprite_pkg::*; (
    input  logic         clock_in,
    input  logic         arst_n,
    input  logic [3:0]   palette_offset,
    input  pixel_item_t  item,
    output pixel_write_t pixel_write
);

    logic                    on_screen;
    logic [ADDRESS_BITS-1:0] row_base;
    logic [ADDRESS_BITS-1:0] address_next;
    logic [3:0]              color_next;

    logic                    write_enable;
    logic [ADDRESS_BITS-1:0] write_address;
    logic [3:0]              write_color;

    // Clip anything off the right or bottom edge
    assign on_screen = (item.x < SCREEN_WIDTH) && (item.y < SCREEN_HEIGHT);

    assign row_base = ADDRESS_BITS'(item.y) * ADDRESS_BITS'(SCREEN_WIDTH);
    assign address_next = row_base + ADDRESS_BITS'(item.x);

    // Wraps modulo 16
    assign color_next = item.index + palette_offset;

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            write_enable <= 1'b0;
        end else begin
            write_enable <= item.valid && on_screen;
        end
    end

    always_ff @(posedge clock_in) begin
        if (item.valid) begin
            write_address <= address_next;
            write_color <= color_next;
        end
    end

    assign pixel_write = '{
        enable:  write_enable,
        address: write_address,
        color:   write_color
    };

    address_in_frame_a: assert property (
        @(posedge clock_in) disable iff (!arst_n)
        pixel_write.enable |-> (pixel_write.address < SCREEN_PIXELS)
    );

endmodule

//--- source/sprite_renderer_top.sv
`timescale 1ns/1ps

module sprite_renderer_top import sprite_pkg::*; (
    input  logic         clock_in,
    input  logic         arst_n,
    input  logic         cmd_valid,
    input  logic [7:0]   cmd_byte,
    output pixel_write_t pixel_write
);

    sprite_setup_t setup;
    sprite_byte_t  data_byte;
    pixel_item_t   item;

    // Command parsing and sprite setup
    command_decoder decoder_i (
        .clock_in (clock_in),
        .arst_n   (arst_n),
        .cmd_valid(cmd_valid),
        .cmd_byte (cmd_byte),
        .setup    (setup),
        .byte_out (data_byte)
    );

    // One pixel per clock with pen movement
    pixel_unpacker unpacker_i (
        .clock_in(clock_in),
        .arst_n  (arst_n),
        .setup   (setup),
        .byte_in (data_byte),
        .item    (item)
    );

    // Palette, clipping and framebuffer address
    pixel_writer writer_i (
        .clock_in      (clock_in),
        .arst_n        (arst_n),
        .palette_offset(setup.palette_offset),
        .item          (item),
        .pixel_write   (pixel_write)
    );

endmodule

//--- testbench/sprite_ref_model.svh
// Pixels per data byte for a mode code where the reserved code counts as 4 bpp
function automatic int pixels_in_byte(input logic [1:0] mode);
    case (mode)
        2'd0: return 8;
        2'd1: return 4;
        default: return 2;
    endcase
endfunction

// Palette index of pixel n counted from the most significant end
function automatic logic [3:0] pixel_at(input logic [7:0] data, input logic [1:0] mode,
                                        input int n);
    int bits;
    int shift;
    bits = 8 / pixels_in_byte(mode);
    shift = 8 - bits * (n + 1);
    return 4'((data >> shift) & ((1 << bits) - 1));
endfunction

// Walks the pen over draw_bytes and queues every on-screen write
function automatic void predict_draw();
    int x;
    int y;
    int col;
    int p;
    int n;
    logic [3:0] idx;
    x = mirror_x;
    y = mirror_y;
    col = 0;
    p = pixels_in_byte(mirror_mode);
    foreach (draw_bytes[i]) begin
        for (n = 0; n < p; n++) begin
            idx = pixel_at(draw_bytes[i], mirror_mode, n);
            if (x < SCREEN_WIDTH && y < SCREEN_HEIGHT) begin
                expected_address.push_back(y * SCREEN_WIDTH + x);
                expected_color.push_back(4'(idx + mirror_offset));
            end
            col++;
            // Row wraps after width pixels even in the middle of a byte
            if (col >= mirror_width) begin
                col = 0;
                x = mirror_x;
                y++;
            end else begin
                x++;
            end
        end
    end
endfunction

//--- testbench/sprite_tb.sv
`timescale 1ns/1ps

module sprite_tb import sprite_pkg::*; ();

    localparam int TOTAL_DATA_BYTES = 36;
    localparam int WATCHDOG_CYCLES = TOTAL_DATA_BYTES * 12 + 2000;

    logic         clock_in;
    logic         arst_n;
    logic         cmd_valid;
    logic [7:0]   cmd_byte;
    pixel_write_t pixel_write;

    // Mirror of the DUT setup
    int          mirror_x;
    int          mirror_y;
    int          mirror_width;
    logic [1:0]  mirror_mode;
    logic [3:0]  mirror_offset;

    logic [7:0]  draw_bytes[$];
    int          expected_address[$];
    logic [3:0]  expected_color[$];
    int          seed;

    `include "sprite_ref_model.svh"

    sprite_renderer_top dut_i (
        .clock_in   (clock_in),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd_byte   (cmd_byte),
        .pixel_write(pixel_write)
    );

    initial begin
        clock_in = 1'b0;
        forever #10 clock_in = ~clock_in;
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        @(posedge clock_in);
        cmd_valid <= 1'b1;
        cmd_byte <= value;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock_in);
            cmd_valid <= 1'b0;
        end
    endtask

    task automatic set_position(input int x, input int y);
        mirror_x = x;
        mirror_y = y;
        send_byte(OP_SET_POSITION);
        send_byte(8'(x >> 8));
        send_byte(8'(x));
        send_byte(8'(y >> 8));
        send_byte(8'(y));
    endtask

    task automatic set_width(input int width);
        mirror_width = width;
        send_byte(OP_SET_WIDTH);
        send_byte(8'(width >> 8));
        send_byte(8'(width));
    endtask

    task automatic set_mode(input bpp_mode_t mode, input logic [3:0] offset);
        mirror_mode = mode;
        mirror_offset = offset;
        send_byte(OP_SET_MODE);
        send_byte({offset, 2'b00, mode});
    endtask

    task automatic fill_random(input int n);
        draw_bytes.delete();
        repeat (n) draw_bytes.push_back(8'($random(seed)));
    endtask

    // Data bytes go out P+1 clocks apart and P+3 idle clocks follow the last one
    task automatic run_draw();
        int p;
        p = pixels_in_byte(mirror_mode);
        predict_draw();
        send_byte(OP_DRAW);
        send_byte(8'(draw_bytes.size() >> 8));
        send_byte(8'(draw_bytes.size()));
        foreach (draw_bytes[i]) begin
            send_byte(draw_bytes[i]);
            idle_cycles(p);
        end
        idle_cycles(3);
    endtask

    // Compare process samples the write port on the falling edge
    initial begin
        int exp_address;
        logic [3:0] exp_color;
        forever begin
            @(negedge clock_in);
            if (pixel_write.enable === 1'b1) begin
                if (expected_address.size() == 0) begin
                    $display("Framebuffer write at %0t with no write expected", $time);
                    $display("Testbench failed");
                    $fatal(1);
                end
                exp_address = expected_address.pop_front();
                exp_color = expected_color.pop_front();
                check_value("address", 32'(pixel_write.address), 32'(exp_address));
                check_value("color", 32'(pixel_write.color), 32'(exp_color));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock_in);
        $display("Timeout after %0d clocks, the tests did not finish", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        arst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd_byte = 8'h00;
        seed = 96859;
        mirror_x = 0;
        mirror_y = 0;
        mirror_width = 1;
        mirror_mode = MODE_4BPP;
        mirror_offset = 4'd0;
        repeat (5) @(posedge clock_in);
        arst_n <= 1'b1;

        // Quiet output after reset and an empty DRAW
        idle_cycles(10);
        draw_bytes.delete();
        run_draw();
        idle_cycles(10);

        // 1 bpp with a row wrap inside the second byte
        set_position(10, 20);
        set_width(12);
        set_mode(MODE_1BPP, 4'd3);
        fill_random(6);
        run_draw();

        // 2 and 4 bpp ordering with offset 14 wrapping the color
        set_mode(MODE_2BPP, 4'd14);
        fill_random(2);
        draw_bytes.push_front(8'h1B);
        draw_bytes.push_front(8'hE4);
        run_draw();
        set_mode(MODE_4BPP, 4'd14);
        fill_random(1);
        draw_bytes.push_front(8'hF0);
        draw_bytes.push_front(8'h2C);
        draw_bytes.push_front(8'h1F);
        run_draw();

        // Bottom right corner where most pixels fall off the screen
        set_position(636, 398);
        set_width(8);
        set_mode(MODE_4BPP, 4'd0);
        fill_random(16);
        run_draw();

        // Unknown opcodes in between and a second DRAW that starts again at the origin
        set_position(100, 50);
        set_width(5);
        send_byte(8'hFF);
        set_mode(MODE_2BPP, 4'd7);
        send_byte(8'h00);
        fill_random(3);
        run_draw();
        send_byte(8'h9C);
        fill_random(3);
        run_draw();

        idle_cycles(10);
        if (expected_address.size() != 0) begin
            $display("%0d expected writes never appeared", expected_address.size());
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+testbench
source/sprite_pkg.sv
source/command_decoder.sv
source/pixel_unpacker.sv
source/pixel_writer.sv
source/sprite_renderer_top.sv
testbench/sprite_tb.sv
